// ==== common/dsp_pkg.sv ====
package dsp_pkg;

   localparam int WB_ADR_W = 32;
   localparam int WB_DAT_W = 32;
   localparam int WB_SEL_W = 4;
   localparam int SAMPLE_W = 16;
   localparam int REGION_W = 4;              // Top address bits seen by the decoder

   // Distributed memory owns the lower half of the address space
   localparam logic DM_MATCH_TOP = 1'b0;

   // Master to slave, 71 bits
   typedef struct packed {
      logic [WB_ADR_W-1:0] adr;
      logic [WB_DAT_W-1:0] dat;
      logic [WB_SEL_W-1:0] sel;
      logic                we;
      logic                cyc;
      logic                stb;
   } wb_req_t;

   // Slave to master, 34 bits
   typedef struct packed {
      logic [WB_DAT_W-1:0] dat;
      logic                ack;
      logic                err;
   } wb_rsp_t;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] re;        // Upper half of the bus word
      logic signed [SAMPLE_W-1:0] im;
   } cplx_t;

   // Register offset inside a transform slave, address bits 3:2
   typedef enum logic [1:0] {
      REG_A    = 2'd0,
      REG_B    = 2'd1,
      REG_SUM  = 2'd2,
      REG_DIFF = 2'd3
   } bfly_reg_e;

   typedef enum logic [1:0] {
      RGN_MEM,
      RGN_DFT,
      RGN_IDFT,
      RGN_ERR
   } region_e;

endpackage

// ==== butterfly/butterfly_arith.sv ====
`timescale 1ns/10ps

module butterfly_arith
   import dsp_pkg::*;
#(
   parameter bit INVERSE = 1'b0
) (
   input  cplx_t a_i,
   input  cplx_t b_i,
   output cplx_t sum_o,
   output cplx_t diff_o
);

   logic signed [SAMPLE_W:0] sum_re;
   logic signed [SAMPLE_W:0] sum_im;
   logic signed [SAMPLE_W:0] dif_re;
   logic signed [SAMPLE_W:0] dif_im;

   // Back to 16 bits, saturate or halve by transform direction
   function automatic logic signed [SAMPLE_W-1:0] fit(input logic signed [SAMPLE_W:0] r);
      logic signed [SAMPLE_W-1:0] res;
      if (INVERSE) begin
         res = r[SAMPLE_W:1];                // 1/N scaling, N = 2
      end else if (r[SAMPLE_W] != r[SAMPLE_W-1]) begin
         res = r[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}}
                           : {1'b0, {(SAMPLE_W-1){1'b1}}};
      end else begin
         res = r[SAMPLE_W-1:0];
      end
      return res;
   endfunction

   // One guard bit, no overflow at 17 bits
   assign sum_re = a_i.re + b_i.re;
   assign sum_im = a_i.im + b_i.im;
   assign dif_re = a_i.re - b_i.re;
   assign dif_im = a_i.im - b_i.im;

   assign sum_o  = '{re: fit(sum_re), im: fit(sum_im)};
   assign diff_o = '{re: fit(dif_re), im: fit(dif_im)};

endmodule

// ==== butterfly/butterfly_slave.sv ====
`timescale 1ns/10ps

module butterfly_slave
   import dsp_pkg::*;
#(
   parameter bit INVERSE = 1'b0
) (
   input  logic    clk,
   input  logic    rst_n_i,

   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   cplx_t     a_q;
   cplx_t     b_q;
   cplx_t     sum;
   cplx_t     diff;
   cplx_t     rdat;
   logic      ack_q;
   logic      req_new;
   bfly_reg_e offset;

   // Byte-lane write into an operand register
   function automatic cplx_t merge_bytes(input cplx_t old,
                                         input logic [WB_DAT_W-1:0] wdat,
                                         input logic [WB_SEL_W-1:0] sel);
      logic [WB_DAT_W-1:0] r;
      r = old;
      for (int i = 0; i < WB_SEL_W; i++) begin
         if (sel[i]) begin
            r[8*i +: 8] = wdat[8*i +: 8];
         end
      end
      return cplx_t'(r);
   endfunction

   assign req_new = req_i.cyc & req_i.stb & ~ack_q;   // Not yet answered
   assign offset  = bfly_reg_e'(req_i.adr[3:2]);       // Upper offset bits alias

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         a_q   <= '0;
         b_q   <= '0;
      end else begin
         ack_q <= req_new;
         if (req_new && req_i.we) begin
            case (offset)
               REG_A:   a_q <= merge_bytes(a_q, req_i.dat, req_i.sel);
               REG_B:   b_q <= merge_bytes(b_q, req_i.dat, req_i.sel);
               default: ;                    // Results are read-only
            endcase
         end
      end
   end

   butterfly_arith #(
      .INVERSE (INVERSE)
   ) u_arith (
      .a_i    (a_q),
      .b_i    (b_q),
      .sum_o  (sum),
      .diff_o (diff)
   );

   // Address is still held during the ack cycle
   always_comb begin
      case (offset)
         REG_A:   rdat = a_q;
         REG_B:   rdat = b_q;
         REG_SUM: rdat = sum;
         default: rdat = diff;
      endcase
   end

   assign rsp_o = '{dat: rdat, ack: ack_q, err: 1'b0};

endmodule

// ==== src/wb_addr_decode.sv ====
`timescale 1ns/10ps

module wb_addr_decode
   import dsp_pkg::*;
#(
   parameter logic [REGION_W-1:0] DFT_REGION  = 4'hf,
   parameter logic [REGION_W-1:0] IDFT_REGION = 4'he
) (
   input  logic    clk,
   input  logic    rst_n_i,

   input  wb_req_t host_req_i,
   output wb_rsp_t host_rsp_o,

   output wb_req_t mem_req_o,
   input  wb_rsp_t mem_rsp_i,

   output wb_req_t dft_req_o,
   input  wb_rsp_t dft_rsp_i,

   output wb_req_t idft_req_o,
   input  wb_rsp_t idft_rsp_i
);

   logic [REGION_W-1:0] top_nib;
   logic                host_act;
   logic                err_q;
   region_e             region;
   wb_rsp_t             err_rsp;

   // Only the selected target ever sees cyc and stb
   function automatic wb_req_t gate_req(input wb_req_t req, input logic en);
      wb_req_t r;
      r     = req;
      r.cyc = req.cyc & en;
      r.stb = req.stb & en;
      return r;
   endfunction

   assign top_nib  = host_req_i.adr[WB_ADR_W-1 -: REGION_W];
   assign host_act = host_req_i.cyc & host_req_i.stb;

   always_comb begin
      if (host_req_i.adr[WB_ADR_W-1] == DM_MATCH_TOP) begin
         region = RGN_MEM;
      end else if (top_nib == DFT_REGION) begin
         region = RGN_DFT;
      end else if (top_nib == IDFT_REGION) begin
         region = RGN_IDFT;
      end else begin
         region = RGN_ERR;                   // Hole in the map
      end
   end

   assign mem_req_o  = gate_req(host_req_i, region == RGN_MEM);
   assign dft_req_o  = gate_req(host_req_i, region == RGN_DFT);
   assign idft_req_o = gate_req(host_req_i, region == RGN_IDFT);

   // One-cycle error pulse, one per request
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= host_act & (region == RGN_ERR) & ~err_q;
      end
   end

   assign err_rsp = '{dat: '0, ack: 1'b0, err: err_q};

   // Address is held until the answer, so the region still picks the source
   always_comb begin
      case (region)
         RGN_MEM:  host_rsp_o = mem_rsp_i;  // Unregistered pass-through
         RGN_DFT:  host_rsp_o = dft_rsp_i;
         RGN_IDFT: host_rsp_o = idft_rsp_i;
         default:  host_rsp_o = err_rsp;
      endcase
   end

endmodule

// ==== src/dsp_subsys.sv ====
`timescale 1ns/10ps

module dsp_subsys
   import dsp_pkg::*;
#(
   parameter logic [REGION_W-1:0] DFT_REGION  = 4'hf,
   parameter logic [REGION_W-1:0] IDFT_REGION = 4'he
) (
   input  logic    clk,
   input  logic    rst_n_i,

   input  wb_req_t wb_req_i,                 // From the tile master
   output wb_rsp_t wb_rsp_o,

   output wb_req_t mem_req_o,                // Out to distributed memory
   input  wb_rsp_t mem_rsp_i
);

   wb_req_t dft_req;
   wb_rsp_t dft_rsp;
   wb_req_t idft_req;
   wb_rsp_t idft_rsp;

   wb_addr_decode #(
      .DFT_REGION  (DFT_REGION),
      .IDFT_REGION (IDFT_REGION)
   ) u_decode (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .host_req_i (wb_req_i),
      .host_rsp_o (wb_rsp_o),
      .mem_req_o  (mem_req_o),
      .mem_rsp_i  (mem_rsp_i),
      .dft_req_o  (dft_req),
      .dft_rsp_i  (dft_rsp),
      .idft_req_o (idft_req),
      .idft_rsp_i (idft_rsp)
   );

   // Forward transform, saturating
   butterfly_slave #(
      .INVERSE (1'b0)
   ) u_dft (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (dft_req),
      .rsp_o   (dft_rsp)
   );

   // Inverse transform, results halved
   butterfly_slave #(
      .INVERSE (1'b1)
   ) u_idft (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (idft_req),
      .rsp_o   (idft_rsp)
   );

endmodule

// ==== dv/dsp_subsys_properties.sv ====
`timescale 1ns/10ps

module dsp_subsys_properties
   import dsp_pkg::*;
(
   input logic    clk,
   input logic    rst_n_i,
   input wb_rsp_t host_rsp_o,
   input wb_req_t mem_req_o,
   input wb_rsp_t dft_rsp_i,
   input wb_rsp_t idft_rsp_i
);

   int num_fails = 0;

   // Exactly one kind of answer at a time
   a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(host_rsp_o.ack && host_rsp_o.err))
      else begin
         num_fails++;
         $error("Host response has ack and err high together");
      end

   a_dft_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      dft_rsp_i.ack |=> !dft_rsp_i.ack)
      else begin
         num_fails++;
         $error("DFT ack held longer than one cycle");
      end

   a_idft_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      idft_rsp_i.ack |=> !idft_rsp_i.ack)
      else begin
         num_fails++;
         $error("IDFT ack held longer than one cycle");
      end

   // Memory only sees its own half of the map
   a_mem_region: assert property (@(posedge clk) disable iff (!rst_n_i)
      mem_req_o.cyc |-> (mem_req_o.adr[WB_ADR_W-1] == DM_MATCH_TOP))
      else begin
         num_fails++;
         $error("Memory cycle started for address %h", mem_req_o.adr);
      end

endmodule

bind wb_addr_decode dsp_subsys_properties u_props (.*);

// ==== dv/tb_dsp_subsys.sv ====
`timescale 1ns/10ps

module tb_dsp_subsys
   import dsp_pkg::*;
();

   localparam logic [REGION_W-1:0] DFT_REGION  = 4'hf;
   localparam logic [REGION_W-1:0] IDFT_REGION = 4'he;
   localparam int TIMEOUT_CYCLES = 20;
   localparam int NUM_OPS        = 400;

   logic    clk = 1'b0;
   logic    rst_n_i;
   wb_req_t wb_req_i;
   wb_rsp_t wb_rsp_o;
   wb_req_t mem_req_o;
   wb_rsp_t mem_rsp_i;

   logic [15:0] lfsr_state = 16'd5948;
   logic [31:0] a_m [2];                     // Operand model with DFT at index 0
   logic [31:0] b_m [2];
   logic [31:0] mem [logic [31:0]];          // Memory model contents
   logic [31:0] mem_adr;                     // Last access seen by memory
   logic [31:0] mem_dat;
   logic [3:0]  mem_sel;
   logic        mem_we;
   int          mem_hits    = 0;
   int          mem_strobes = 0;             // Cycles with cyc or stb toward memory
   int          num_checks  = 0;
   int          num_errors  = 0;
   int          num_tmo     = 0;

   always #5 clk = ~clk;

   dsp_subsys #(
      .DFT_REGION  (DFT_REGION),
      .IDFT_REGION (IDFT_REGION)
   ) u_dut (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wb_req_i  (wb_req_i),
      .wb_rsp_o  (wb_rsp_o),
      .mem_req_o (mem_req_o),
      .mem_rsp_i (mem_rsp_i)
   );

   // Galois form with taps 16 14 13 11
   function automatic logic next_bit();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
         lfsr_state = lfsr_state ^ 16'hb400;
      end
      return out;
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], next_bit()};
      end
      return r;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
      num_checks++;
      if (got !== exp) begin
         num_errors++;
         $display("[FAIL] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // Unwritten words read back a pattern tied to the full address
   function automatic logic [31:0] mem_word(input logic [31:0] adr);
      if (mem.exists(adr)) begin
         return mem[adr];
      end
      return {adr[15:0], adr[31:16]} ^ 32'h5a5a_3c3c;
   endfunction

   task automatic mem_serve();
      logic [31:0] word;
      mem_hits++;
      mem_adr = mem_req_o.adr;
      mem_dat = mem_req_o.dat;
      mem_sel = mem_req_o.sel;
      mem_we  = mem_req_o.we;
      word    = mem_word(mem_req_o.adr);
      if (mem_req_o.we) begin
         for (int i = 0; i < 4; i++) begin
            if (mem_req_o.sel[i]) begin
               word[8*i +: 8] = mem_req_o.dat[8*i +: 8];
            end
         end
         mem[mem_req_o.adr] = word;
         word = '0;
      end
      mem_rsp_i = '{dat: word, ack: 1'b1, err: 1'b0};
   endtask

   // One classic cycle with the memory model in the same loop
   task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat,
                             output logic [1:0] resp);
      int   cycles;
      int   mem_wait;
      logic done;
      cycles   = 0;
      mem_wait = -1;
      done     = 1'b0;
      rdat     = '0;
      resp     = 2'b00;
      wb_req_i = '{adr: adr, dat: wdat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      while (!done && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (mem_req_o.cyc || mem_req_o.stb) begin
            mem_strobes++;
         end
         if (wb_rsp_o.ack || wb_rsp_o.err) begin
            rdat = wb_rsp_o.dat;
            resp = {wb_rsp_o.ack, wb_rsp_o.err};
            done = 1'b1;
         end
         if (mem_req_o.cyc && mem_req_o.stb && !mem_rsp_i.ack && !done) begin
            if (mem_wait < 0) begin
               mem_wait = draw_bits(2);      // Stall of 0 to 3 cycles
            end
            if (mem_wait == 0) begin
               mem_serve();
            end else begin
               mem_wait--;
            end
         end else begin
            mem_rsp_i = '0;
         end
      end
      wb_req_i.cyc = 1'b0;
      wb_req_i.stb = 1'b0;
      mem_rsp_i    = '0;
      if (!done) begin
         num_tmo++;
         $display("Timeout at %0t ns: no ack or err for address %h", $time, adr);
      end
      @(negedge clk);                        // stb low for a cycle after the answer
   endtask

   function automatic logic [15:0] scale(input int r, input bit inv);
      if (inv) begin
         return 16'(r >>> 1);                // Floor as in an arithmetic shift
      end
      if (r > 32767) begin
         return 16'h7fff;
      end
      if (r < -32768) begin
         return 16'h8000;
      end
      return 16'(r);
   endfunction

   function automatic logic [31:0] expect_read(input int s, input logic [1:0] off);
      int ar;
      int ai;
      int br;
      int bi;
      ar = $signed(a_m[s][31:16]);
      ai = $signed(a_m[s][15:0]);
      br = $signed(b_m[s][31:16]);
      bi = $signed(b_m[s][15:0]);
      case (off)
         2'd0:    return a_m[s];
         2'd1:    return b_m[s];
         2'd2:    return {scale(ar + br, s == 1), scale(ai + bi, s == 1)};
         default: return {scale(ar - br, s == 1), scale(ai - bi, s == 1)};
      endcase
   endfunction

   function automatic void model_write(input int s, input logic [1:0] off,
                                       input logic [31:0] d, input logic [3:0] sel);
      for (int i = 0; i < 4; i++) begin
         if (sel[i] && off == 2'd0) begin
            a_m[s][8*i +: 8] = d[8*i +: 8];
         end else if (sel[i] && off == 2'd1) begin
            b_m[s][8*i +: 8] = d[8*i +: 8];
         end
      end
   endfunction

   // Target 0 DFT, 1 IDFT, 2 memory, 3 unmapped
   task automatic do_op(input int tgt, input logic [1:0] off, input logic we,
                        input logic [31:0] wdat, input logic [3:0] sel);
      logic [31:0] adr;
      logic [31:0] rnd;
      logic [31:0] rdat;
      logic [1:0]  resp;
      int          hits_before;
      int          strobes_before;
      hits_before    = mem_hits;
      strobes_before = mem_strobes;
      rnd            = draw_bits((tgt == 2) ? 7 : 2);
      case (tgt)
         0:       adr = {DFT_REGION, 22'h0, rnd[1:0], off, 2'b00};   // Alias bits set too
         1:       adr = {IDFT_REGION, 22'h0, rnd[1:0], off, 2'b00};
         2:       adr = {1'b0, rnd[6:4], 20'h0, 2'b00, rnd[3:0], 2'b00};
         default: adr = {2'b10, rnd[1:0], 28'h0};                    // Nibble 8 to b
      endcase
      bus_access(adr, we, wdat, sel, rdat, resp);
      check_value({30'h0, resp}, (tgt == 3) ? 32'h1 : 32'h2,
                  $sformatf("ack/err response for address %h", adr));
      if (tgt == 2) begin
         check_value(mem_hits, hits_before + 1, "memory access count");
         check_value(mem_adr, adr, "memory address");
         check_value({31'h0, mem_we}, {31'h0, we}, "memory write enable");
         check_value({28'h0, mem_sel}, {28'h0, sel}, "memory byte select");
         if (we) begin
            check_value(mem_dat, wdat, "memory write data");
         end else begin
            check_value(rdat, mem_word(adr), $sformatf("memory read at %h", adr));
         end
      end else begin
         check_value(mem_strobes, strobes_before, "memory strobed by non-memory access");
         if (tgt == 3) begin
            check_value(rdat, '0, "error response data");
         end else if (we) begin
            model_write(tgt, off, wdat, sel);
         end else begin
            check_value(rdat, expect_read(tgt, off),
                        $sformatf("slave %0d offset %0d read", tgt, off));
         end
      end
   endtask

   initial begin
      int          tgt;
      logic [31:0] rnd;
      logic [3:0]  sel;
      rst_n_i   = 1'b0;
      wb_req_i  = '0;
      mem_rsp_i = '0;
      a_m       = '{default: '0};
      b_m       = '{default: '0};
      repeat (5) @(negedge clk);
      rst_n_i = 1'b1;

      // Overflow in both directions, then a write to the result offsets
      for (int s = 0; s < 2; s++) begin
         do_op(s, 2'd0, 1'b1, 32'h7fff_8000, 4'hf);
         for (int k = 0; k < 2; k++) begin
            do_op(s, 2'd1, 1'b1, (k == 0) ? 32'h0001_ffff : 32'hffff_0001, 4'hf);
            do_op(s, 2'd2, 1'b0, '0, 4'hf);
            do_op(s, 2'd3, 1'b0, '0, 4'hf);
         end
         do_op(s, 2'd2, 1'b1, 32'hdead_beef, 4'hf);
         do_op(s, 2'd3, 1'b1, 32'hbeef_dead, 4'hf);
         do_op(s, 2'd2, 1'b0, '0, 4'hf);
      end

      for (int n = 0; n < NUM_OPS; n++) begin
         rnd = draw_bits(4);
         if (rnd < 6) begin
            tgt = 0;
         end else if (rnd < 12) begin
            tgt = 1;
         end else if (rnd < 15) begin
            tgt = 2;
         end else begin
            tgt = 3;
         end
         sel = next_bit() ? 4'hf : 4'(draw_bits(4));   // Mostly whole words
         do_op(tgt, 2'(draw_bits(2)), next_bit(), draw_bits(32), sel);
      end

      $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
               num_checks, num_errors, num_tmo, u_dut.u_decode.u_props.num_fails);
      if (num_errors == 0 && num_tmo == 0 && u_dut.u_decode.u_props.num_fails == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
common/dsp_pkg.sv
butterfly/butterfly_arith.sv
butterfly/butterfly_slave.sv
src/wb_addr_decode.sv
src/dsp_subsys.sv
dv/dsp_subsys_properties.sv
dv/tb_dsp_subsys.sv
